// ==== design/panel_pkg.sv ====
// panel controller shared definitions
// widths, opcode encoding and the request structs passed between blocks

`default_nettype none

package panel_pkg;

    // framebuffer geometry and brightness depth
    localparam int unsigned FB_ADDR_W = 10;
    localparam int unsigned BRIGHTNESS_LEVELS = 6;

    typedef logic [7:0] cmd_byte_t;
    typedef logic [7:0] pixel_t;
    typedef logic [FB_ADDR_W-1:0] fb_addr_t;
    // one extra bit so a count of the whole framebuffer fits
    typedef logic [FB_ADDR_W:0] fb_count_t;
    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

    typedef enum logic [7:0] {
        // colour channel enables
        RED_ENABLE       = 8'h10,
        RED_DISABLE      = 8'h11,
        GREEN_ENABLE     = 8'h12,
        GREEN_DISABLE    = 8'h13,
        BLUE_ENABLE      = 8'h14,
        BLUE_DISABLE     = 8'h15,
        // brightness mask, ONE..SIX flip a single bit
        BRIGHTNESS_ZERO  = 8'h20,
        BRIGHTNESS_ONE   = 8'h21,
        BRIGHTNESS_TWO   = 8'h22,
        BRIGHTNESS_THREE = 8'h23,
        BRIGHTNESS_FOUR  = 8'h24,
        BRIGHTNESS_FIVE  = 8'h25,
        BRIGHTNESS_SIX   = 8'h26,
        BRIGHTNESS_FULL  = 8'h29,
        // followed by one mask byte
        READ_BRIGHTNESS  = 8'h30,
        // framebuffer commands
        BLANK_PANEL      = 8'h40,
        FILL_PANEL       = 8'h41,
        WRITE_PIXEL      = 8'h42
    } opcode_t;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_enable_t;

    // register update, decoder to register block
    typedef struct packed {
        logic      valid;
        opcode_t   op;
        cmd_byte_t arg;
    } cfg_req_t;

    // one write engine run
    typedef struct packed {
        fb_addr_t  base;
        fb_count_t count;
        pixel_t    value;
    } fb_req_t;

    // single framebuffer write beat
    typedef struct packed {
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_t;

endpackage

`default_nettype wire

// ==== design/cmd_decoder.sv ====
// command byte decoder
// collects command arguments, forwards register updates and launches write engine runs

`timescale 1ns/1ps
`default_nettype none

module cmd_decoder #(
    parameter int unsigned FB_DEPTH = 1 << panel_pkg::FB_ADDR_W
) (
    input  wire                        clk_in,
    input  wire                        reset,
    input  wire  panel_pkg::cmd_byte_t cmd_byte,
    input  wire                        cmd_valid,
    input  wire                        fb_done,
    output logic                       cmd_ready,
    output panel_pkg::cfg_req_t        cfg_req,
    output logic                       fb_start,
    output panel_pkg::fb_req_t         fb_req
);
    import panel_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        BRIGHTNESS_ARG,
        FILL_ARG,
        PIXEL_ADDR_HI,
        PIXEL_ADDR_LO,
        PIXEL_DATA,
        WAIT_ENGINE
    } dec_state_t;

    localparam fb_count_t FULL_COUNT = fb_count_t'(FB_DEPTH);

    dec_state_t state;
    dec_state_t state_next;
    opcode_t    opcode;
    logic       accept;
    logic       launch;

    assign opcode = opcode_t'(cmd_byte);

    // no bytes are taken while an engine run is outstanding
    assign cmd_ready = (state != WAIT_ENGINE);
    assign accept = cmd_valid && cmd_ready;

    // every non-wait state only reaches WAIT_ENGINE on the last byte of a command
    assign launch = (state != WAIT_ENGINE) && (state_next == WAIT_ENGINE);

    always_comb begin
        cfg_req.valid = 1'b0;
        cfg_req.op = opcode;
        cfg_req.arg = cmd_byte;
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    case (opcode)
                        READ_BRIGHTNESS: state_next = BRIGHTNESS_ARG;
                        BLANK_PANEL: state_next = WAIT_ENGINE;
                        FILL_PANEL: state_next = FILL_ARG;
                        WRITE_PIXEL: state_next = PIXEL_ADDR_HI;
                        // single byte codes go to the register block that drops unknown ones
                        default: cfg_req.valid = 1'b1;
                    endcase
                end
            end
            BRIGHTNESS_ARG: begin
                if (accept) begin
                    cfg_req.valid = 1'b1;
                    cfg_req.op = READ_BRIGHTNESS;
                    state_next = IDLE;
                end
            end
            FILL_ARG: begin
                if (accept) begin
                    state_next = WAIT_ENGINE;
                end
            end
            PIXEL_ADDR_HI: begin
                if (accept) begin
                    state_next = PIXEL_ADDR_LO;
                end
            end
            PIXEL_ADDR_LO: begin
                if (accept) begin
                    state_next = PIXEL_DATA;
                end
            end
            PIXEL_DATA: begin
                if (accept) begin
                    state_next = WAIT_ENGINE;
                end
            end
            WAIT_ENGINE: begin
                if (fb_done) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
            fb_start <= 1'b0;
        end else begin
            state <= state_next;
            fb_start <= launch;
        end
    end

    // request fields are built up as argument bytes arrive
    always_ff @(posedge clk_in) begin
        if (accept) begin
            case (state)
                IDLE: begin
                    if (opcode == BLANK_PANEL) begin
                        fb_req.base <= '0;
                        fb_req.count <= FULL_COUNT;
                        fb_req.value <= '0;
                    end
                end
                FILL_ARG: begin
                    fb_req.base <= '0;
                    fb_req.count <= FULL_COUNT;
                    fb_req.value <= cmd_byte;
                end
                PIXEL_ADDR_HI: begin
                    // upper address bits come first and the low byte follows
                    fb_req.base <= fb_addr_t'({cmd_byte, 8'h00});
                end
                PIXEL_ADDR_LO: begin
                    fb_req.base[7:0] <= cmd_byte;
                end
                PIXEL_DATA: begin
                    fb_req.count <= fb_count_t'(1);
                    fb_req.value <= cmd_byte;
                end
                default: begin
                end
            endcase
        end
    end

    // engine done only arrives for the run being waited on and never in its launch cycle
    a_single_run: assert property (@(posedge clk_in) disable iff (reset)
        fb_done |-> ((state == WAIT_ENGINE) && !fb_start));

endmodule

`default_nettype wire

// ==== design/panel_config_regs.sv ====
// colour enable and brightness mask registers
// applies register updates from the command decoder

`timescale 1ns/1ps
`default_nettype none

module panel_config_regs (
    input  wire                       clk_in,
    input  wire                       reset,
    input  wire  panel_pkg::cfg_req_t cfg_req,
    output panel_pkg::rgb_enable_t    rgb_enable,
    output panel_pkg::brightness_t    brightness
);
    import panel_pkg::*;

    brightness_t flip_mask;

    // opcode n selects mask bit BRIGHTNESS_LEVELS-n
    always_comb begin
        flip_mask = '0;
        case (cfg_req.op)
            BRIGHTNESS_ONE:   flip_mask[BRIGHTNESS_LEVELS-1] = 1'b1;
            BRIGHTNESS_TWO:   flip_mask[BRIGHTNESS_LEVELS-2] = 1'b1;
            BRIGHTNESS_THREE: flip_mask[BRIGHTNESS_LEVELS-3] = 1'b1;
            BRIGHTNESS_FOUR:  flip_mask[BRIGHTNESS_LEVELS-4] = 1'b1;
            BRIGHTNESS_FIVE:  flip_mask[BRIGHTNESS_LEVELS-5] = 1'b1;
            BRIGHTNESS_SIX:   flip_mask[BRIGHTNESS_LEVELS-6] = 1'b1;
            default:          flip_mask = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= '1;
            brightness <= '1;
        end else if (cfg_req.valid) begin
            case (cfg_req.op)
                RED_ENABLE:      rgb_enable.red <= 1'b1;
                RED_DISABLE:     rgb_enable.red <= 1'b0;
                GREEN_ENABLE:    rgb_enable.green <= 1'b1;
                GREEN_DISABLE:   rgb_enable.green <= 1'b0;
                BLUE_ENABLE:     rgb_enable.blue <= 1'b1;
                BLUE_DISABLE:    rgb_enable.blue <= 1'b0;
                BRIGHTNESS_ZERO: brightness <= '0;
                BRIGHTNESS_FULL: brightness <= '1;
                READ_BRIGHTNESS: brightness <= cfg_req.arg[BRIGHTNESS_LEVELS-1:0];
                // single bit toggles, unknown codes leave the mask alone
                default:         brightness <= brightness ^ flip_mask;
            endcase
        end
    end

    // framebuffer commands go to the write engine, never here
    a_no_fb_op: assert property (@(posedge clk_in) disable iff (reset)
        cfg_req.valid |-> !(cfg_req.op inside {BLANK_PANEL, FILL_PANEL, WRITE_PIXEL}));

endmodule

`default_nettype wire

// ==== design/fb_write_engine.sv ====
// framebuffer write sequencer
// issues count writes of one value from a base address, advancing on each handshake

`timescale 1ns/1ps
`default_nettype none

module fb_write_engine (
    input  wire                      clk_in,
    input  wire                      reset,
    input  wire                      fb_start,
    input  wire  panel_pkg::fb_req_t fb_req,
    input  wire                      fb_ready,
    output logic                     fb_valid,
    output panel_pkg::fb_write_t     fb_write,
    output logic                     fb_done
);
    import panel_pkg::*;

    fb_addr_t  run_addr;
    pixel_t    run_value;
    fb_count_t remaining;
    logic      handshake;
    logic      last;

    assign handshake = fb_valid && fb_ready;
    assign last = (remaining == fb_count_t'(1));
    assign fb_done = handshake && last;

    assign fb_write = '{addr: run_addr, data: run_value};

    always_ff @(posedge clk_in) begin
        if (reset) begin
            fb_valid <= 1'b0;
            remaining <= '0;
        end else if (fb_start) begin
            fb_valid <= 1'b1;
            remaining <= fb_req.count;
        end else if (handshake) begin
            remaining <= remaining - fb_count_t'(1);
            if (last) begin
                fb_valid <= 1'b0;
            end
        end
    end

    // address and value only move on start or an accepted write
    always_ff @(posedge clk_in) begin
        if (fb_start) begin
            run_addr <= fb_req.base;
            run_value <= fb_req.value;
        end else if (handshake) begin
            run_addr <= run_addr + fb_addr_t'(1);
        end
    end

    // a stalled write must not change until it is taken
    a_hold_stalled: assert property (@(posedge clk_in) disable iff (reset)
        (fb_valid && !fb_ready) |=> (fb_valid && $stable(fb_write)));

endmodule

`default_nettype wire

// ==== design/panel_ctrl_top.sv ====
// led panel controller command front end
// byte decoder, configuration registers and framebuffer write engine

`timescale 1ns/1ps
`default_nettype none

module panel_ctrl_top #(
    parameter int unsigned FB_DEPTH = 1 << panel_pkg::FB_ADDR_W
) (
    input  wire                          clk_in,
    input  wire                          reset,
    input  wire  panel_pkg::cmd_byte_t   cmd_byte,
    input  wire                          cmd_valid,
    input  wire                          fb_ready,
    output wire                          cmd_ready,
    output wire                          fb_valid,
    output wire  panel_pkg::fb_write_t   fb_write,
    output wire  panel_pkg::rgb_enable_t rgb_enable,
    output wire  panel_pkg::brightness_t brightness
);
    import panel_pkg::*;

    wire cfg_req_t cfg_req;
    wire fb_req_t  fb_req;
    wire           fb_start;
    wire           fb_done;

    cmd_decoder #(
        .FB_DEPTH(FB_DEPTH)
    ) u_decoder (
        .clk_in   (clk_in),
        .reset    (reset),
        .cmd_byte (cmd_byte),
        .cmd_valid(cmd_valid),
        .fb_done  (fb_done),
        .cmd_ready(cmd_ready),
        .cfg_req  (cfg_req),
        .fb_start (fb_start),
        .fb_req   (fb_req)
    );

    panel_config_regs u_regs (
        .clk_in    (clk_in),
        .reset     (reset),
        .cfg_req   (cfg_req),
        .rgb_enable(rgb_enable),
        .brightness(brightness)
    );

    fb_write_engine u_engine (
        .clk_in  (clk_in),
        .reset   (reset),
        .fb_start(fb_start),
        .fb_req  (fb_req),
        .fb_ready(fb_ready),
        .fb_valid(fb_valid),
        .fb_write(fb_write),
        .fb_done (fb_done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_panel_tasks.svh ====
// stimulus tasks for the panel controller testbench
// byte handshake, whole commands and random write back-pressure

`ifndef TB_PANEL_TASKS_SVH
`define TB_PANEL_TASKS_SVH

// inputs change 1 ns after the rising edge
task automatic next_drive_point();
    @(posedge clk_in);
    #1;
endtask

task automatic idle_cycles(input int unsigned n);
    repeat (n) next_drive_point();
endtask

// byte and valid stay put until the cycle where cmd_ready is high
task automatic send_byte(input cmd_byte_t value);
    logic taken;
    cmd_byte = value;
    cmd_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
        taken = cmd_ready;
        next_drive_point();
    end
    cmd_valid = 1'b0;
endtask

task automatic wait_engine_idle();
    while (!cmd_ready) next_drive_point();
endtask

task automatic load_brightness(input cmd_byte_t mask);
    send_byte(READ_BRIGHTNESS);
    send_byte(mask);
endtask

task automatic blank_panel();
    send_byte(BLANK_PANEL);
    wait_engine_idle();
endtask

task automatic fill_panel(input pixel_t colour);
    send_byte(FILL_PANEL);
    send_byte(colour);
    wait_engine_idle();
endtask

// high address byte carries bits 9:8 in its low end
task automatic write_pixel(input fb_addr_t addr, input pixel_t data);
    send_byte(WRITE_PIXEL);
    send_byte({6'b000000, addr[9:8]});
    send_byte(addr[7:0]);
    send_byte(data);
    wait_engine_idle();
endtask

task automatic colour_sequence();
    send_byte(RED_DISABLE);
    send_byte(GREEN_DISABLE);
    send_byte(BLUE_DISABLE);
    send_byte(GREEN_ENABLE);
    send_byte(RED_ENABLE);
    send_byte(BLUE_ENABLE);
endtask

task automatic brightness_sequence();
    send_byte(BRIGHTNESS_ZERO);
    for (int n = 0; n < 6; n++) begin
        send_byte(cmd_byte_t'(BRIGHTNESS_ONE) + cmd_byte_t'(n));
    end
    send_byte(BRIGHTNESS_THREE);
    send_byte(BRIGHTNESS_SIX);
    send_byte(BRIGHTNESS_FULL);
endtask

// codes that are not opcodes such as the gap below BRIGHTNESS_FULL
task automatic unknown_sequence();
    send_byte(8'h00);
    send_byte(8'h27);
    send_byte(8'h7e);
    send_byte(8'hff);
endtask

// about half of the cycles accept a write
task automatic drive_fb_ready();
    logic [31:0] rnd;
    forever begin
        next_drive_point();
        rnd = $urandom;
        fb_ready = rnd[0];
    end
endtask

`endif

// ==== testbench/tb_panel_ctrl.sv ====
// testbench for the led panel controller command front end
// a reference model tracks registers and the write stream for the assertions to compare

`timescale 1ns/1ps
`default_nettype none

module tb_panel_ctrl;
    import panel_pkg::*;

    localparam int unsigned FB_DEPTH = 64;
    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED = 32'h016f3196;

    // parser state of the reference model
    typedef enum logic [2:0] {
        M_IDLE,
        M_BRIGHTNESS,
        M_FILL,
        M_ADDR_HI,
        M_ADDR_LO,
        M_DATA
    } model_state_t;

    logic        clk_in;
    logic        reset;
    cmd_byte_t   cmd_byte;
    logic        cmd_valid;
    logic        fb_ready;
    wire         cmd_ready;
    wire         fb_valid;
    wire         fb_write_t fb_write;
    wire         rgb_enable_t rgb_enable;
    wire         brightness_t brightness;

    rgb_enable_t  exp_rgb;
    brightness_t  exp_bright;
    fb_write_t    exp_write;
    fb_count_t    exp_remaining;
    model_state_t model_state;
    cmd_byte_t    addr_hi;
    int unsigned  cycle_count = 0;
    logic [31:0]  stim_rnd;
    fb_addr_t     pixel_addr;

    panel_ctrl_top #(
        .FB_DEPTH(FB_DEPTH)
    ) uut (
        .clk_in    (clk_in),
        .reset     (reset),
        .cmd_byte  (cmd_byte),
        .cmd_valid (cmd_valid),
        .fb_ready  (fb_ready),
        .cmd_ready (cmd_ready),
        .fb_valid  (fb_valid),
        .fb_write  (fb_write),
        .rgb_enable(rgb_enable),
        .brightness(brightness)
    );

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_panel_tasks.svh"

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // reference model updates at the edge where a byte or a write is taken
    always @(posedge clk_in) begin
        if (reset) begin
            exp_rgb <= '1;
            exp_bright <= '1;
            exp_write <= '0;
            exp_remaining <= '0;
            model_state <= M_IDLE;
            addr_hi <= '0;
        end else begin
            if (fb_valid && fb_ready) begin
                exp_write.addr <= exp_write.addr + fb_addr_t'(1);
                exp_remaining <= exp_remaining - fb_count_t'(1);
            end
            if (cmd_valid && cmd_ready) begin
                case (model_state)
                    M_IDLE: begin
                        case (cmd_byte)
                            RED_ENABLE:       exp_rgb.red <= 1'b1;
                            RED_DISABLE:      exp_rgb.red <= 1'b0;
                            GREEN_ENABLE:     exp_rgb.green <= 1'b1;
                            GREEN_DISABLE:    exp_rgb.green <= 1'b0;
                            BLUE_ENABLE:      exp_rgb.blue <= 1'b1;
                            BLUE_DISABLE:     exp_rgb.blue <= 1'b0;
                            BRIGHTNESS_ZERO:  exp_bright <= '0;
                            BRIGHTNESS_FULL:  exp_bright <= '1;
                            BRIGHTNESS_ONE:   exp_bright[5] <= ~exp_bright[5];
                            BRIGHTNESS_TWO:   exp_bright[4] <= ~exp_bright[4];
                            BRIGHTNESS_THREE: exp_bright[3] <= ~exp_bright[3];
                            BRIGHTNESS_FOUR:  exp_bright[2] <= ~exp_bright[2];
                            BRIGHTNESS_FIVE:  exp_bright[1] <= ~exp_bright[1];
                            BRIGHTNESS_SIX:   exp_bright[0] <= ~exp_bright[0];
                            READ_BRIGHTNESS:  model_state <= M_BRIGHTNESS;
                            FILL_PANEL:       model_state <= M_FILL;
                            WRITE_PIXEL:      model_state <= M_ADDR_HI;
                            BLANK_PANEL: begin
                                exp_write <= '0;
                                exp_remaining <= fb_count_t'(FB_DEPTH);
                            end
                            default: begin
                            end
                        endcase
                    end
                    M_BRIGHTNESS: begin
                        exp_bright <= cmd_byte[5:0];
                        model_state <= M_IDLE;
                    end
                    M_FILL: begin
                        exp_write <= '{addr: '0, data: cmd_byte};
                        exp_remaining <= fb_count_t'(FB_DEPTH);
                        model_state <= M_IDLE;
                    end
                    M_ADDR_HI: begin
                        addr_hi <= cmd_byte;
                        model_state <= M_ADDR_LO;
                    end
                    M_ADDR_LO: begin
                        exp_write.addr <= fb_addr_t'({addr_hi, cmd_byte});
                        model_state <= M_DATA;
                    end
                    default: begin
                        exp_write.data <= cmd_byte;
                        exp_remaining <= fb_count_t'(1);
                        model_state <= M_IDLE;
                    end
                endcase
            end
        end
    end

    a_reset_state: assert property (@(posedge clk_in) $fell(reset) |->
        (rgb_enable == 3'b111 && brightness == '1 && !fb_valid && cmd_ready))
        else begin
            $display("outputs were not at their reset values when reset was released");
            abort_run();
        end

    a_rgb: assert property (@(posedge clk_in) disable iff (reset) rgb_enable == exp_rgb)
        else begin
            $display("ERR %0t rgb_enable expected %b actual %b", $time,
                $sampled(exp_rgb), $sampled(rgb_enable));
            abort_run();
        end

    a_brightness: assert property (@(posedge clk_in) disable iff (reset)
        brightness == exp_bright)
        else begin
            $display("ERR %0t brightness expected %b actual %b", $time,
                $sampled(exp_bright), $sampled(brightness));
            abort_run();
        end

    a_write_addr: assert property (@(posedge clk_in) disable iff (reset)
        fb_valid |-> fb_write.addr == exp_write.addr)
        else begin
            $display("ERR %0t fb_write.addr expected %0d actual %0d", $time,
                $sampled(exp_write.addr), $sampled(fb_write.addr));
            abort_run();
        end

    a_write_data: assert property (@(posedge clk_in) disable iff (reset)
        fb_valid |-> fb_write.data == exp_write.data)
        else begin
            $display("ERR %0t fb_write.data expected %h actual %h", $time,
                $sampled(exp_write.data), $sampled(fb_write.data));
            abort_run();
        end

    // cmd_ready is low exactly while writes of a run are still owed
    a_ready: assert property (@(posedge clk_in) disable iff (reset)
        cmd_ready == (exp_remaining == '0))
        else begin
            $display("ERR %0t cmd_ready expected %b actual %b", $time,
                $sampled(exp_remaining == '0), $sampled(cmd_ready));
            abort_run();
        end

    a_no_extra_write: assert property (@(posedge clk_in) disable iff (reset)
        fb_valid |-> exp_remaining != '0)
        else begin
            $display("a framebuffer write was offered that no command asked for");
            abort_run();
        end

    a_stall_hold: assert property (@(posedge clk_in) disable iff (reset)
        (fb_valid && !fb_ready) |=> (fb_valid && $stable(fb_write)))
        else begin
            $display("a stalled framebuffer write changed or was withdrawn");
            abort_run();
        end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the command sequence had not finished after %0d cycles",
                cycle_count);
            abort_run();
        end
    end

    initial begin
        stim_rnd = $urandom(SEED);
        reset = 1'b1;
        cmd_byte = '0;
        cmd_valid = 1'b0;
        fb_ready = 1'b0;
        fork
            drive_fb_ready();
        join_none
        repeat (4) @(posedge clk_in);
        #1;
        reset = 1'b0;
        idle_cycles(2);
        colour_sequence();
        brightness_sequence();
        stim_rnd = $urandom;
        load_brightness(stim_rnd[7:0]);
        blank_panel();
        stim_rnd = $urandom;
        fill_panel(stim_rnd[7:0]);
        repeat (3) begin
            stim_rnd = $urandom;
            pixel_addr = stim_rnd[9:0];
            write_pixel(pixel_addr, stim_rnd[23:16]);
        end
        unknown_sequence();
        idle_cycles(4);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+testbench
design/panel_pkg.sv
design/cmd_decoder.sv
design/panel_config_regs.sv
design/fb_write_engine.sv
design/panel_ctrl_top.sv
testbench/tb_panel_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_panel_ctrl \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_panel_ctrl > sim.log 2>&1
cat sim.log

grep -qx "Simulation completed successfully" sim.log && exit 0 || exit 1
